// File: hw/vlb_buffer_avail.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_buffer_avail (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_snapshot,
    input  vlb_pkg::queue_vec_t i_local_size,
    input  vlb_pkg::queue_vec_t i_unlocal_size,
    input  vlb_pkg::queue_vec_t i_relay,
    input  logic                i_relay_valid,
    output vlb_pkg::queue_vec_t o_avail
);

    import vlb_pkg::*;

    queue_vec_t r_local;
    queue_vec_t r_unlocal;
    logic       r_load;

    ////////////////////////////////////////////////////////////////////////////
    // queue size snapshot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_local   <= '0;
            r_unlocal <= '0;
            r_load    <= 1'b0;
        end else begin
            r_load <= i_snapshot;
            if (i_snapshot) begin
                r_local   <= i_local_size;
                r_unlocal <= i_unlocal_size;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // available space per destination
    ////////////////////////////////////////////////////////////////////////////

    // refill wins over a grant landing in the same cycle
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_avail <= '0;
        end else if (r_load) begin
            for (int q = 0; q < QUEUE_NUM; q++) begin
                o_avail[q] <= SLOT_MAX_PKT - r_local[q] - r_unlocal[q];
            end
        end else if (i_relay_valid) begin
            // grants never exceed avail, so no wrap
            for (int q = 0; q < QUEUE_NUM; q++) begin
                o_avail[q] <= o_avail[q] - i_relay[q];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vlb_next_hop.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_next_hop (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_load,
    input  logic [vlb_pkg::SLOT_W-1:0] i_slot_id,
    output vlb_pkg::next_hop_t         o_next_hop
);

    import vlb_pkg::*;

    logic [SLOT_W-1:0] w_next_slot;
    next_hop_t         w_hop;

    assign w_next_slot = SLOT_W'((int'(i_slot_id) + 1) % SLOT_NUM);

    ////////////////////////////////////////////////////////////////////////////
    // rotating route rule
    ////////////////////////////////////////////////////////////////////////////

    // even switch walks up two racks per slot, odd switch walks down
    always_comb begin
        w_hop.ocs0_tor = TOR_W'((MY_TOR_ID + 1 + 2 * int'(w_next_slot)) % TOR_NUM);
        // offset keeps the odd side positive before the modulo
        w_hop.ocs1_tor = TOR_W'((MY_TOR_ID + 2 * SLOT_NUM * TOR_NUM - 1
                                 - 2 * int'(w_next_slot)) % TOR_NUM);
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_next_hop <= '0;
        end else if (i_load) begin
            o_next_hop <= w_hop;
        end
    end

endmodule

`default_nettype wire

// File: hw/vlb_pkg.sv
`default_nettype none

package vlb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    // one queue per destination rack
    localparam int QUEUE_NUM = 8;
    localparam int TOR_NUM   = 8;
    localparam int TOR_W     = 3;

    // each switch cycles through this many slots
    localparam int SLOT_NUM  = 2;
    localparam int SLOT_W    = 1;

    localparam int SIZE_W    = 32;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int MY_TOR_ID = 0;

    // relay buffer space per destination and slot
    localparam logic [SIZE_W-1:0] SLOT_MAX_PKT = 32'h0004_0000;

    // resp ready crosses from the queue manager domain
    localparam int SYNC_STAGES = 3;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [QUEUE_NUM-1:0][SIZE_W-1:0] queue_vec_t;

    typedef struct packed {
        logic [SIZE_W-1:0] capacity;
        queue_vec_t        sizes;
    } offer_t;

    typedef struct packed {
        logic [TOR_W-1:0] ocs0_tor;
        logic [TOR_W-1:0] ocs1_tor;
    } next_hop_t;

endpackage

`default_nettype wire

// File: hw/vlb_relay_calc.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_relay_calc (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_compute,
    input  logic                i_port,
    input  vlb_pkg::offer_t     i_offer0,
    input  vlb_pkg::offer_t     i_offer1,
    input  vlb_pkg::next_hop_t  i_next_hop,
    input  vlb_pkg::queue_vec_t i_avail,
    output vlb_pkg::queue_vec_t o_relay,
    output logic                o_relay_valid,
    output logic                o_relay_port
);

    import vlb_pkg::*;

    offer_t            r_offer0;
    offer_t            r_offer1;
    offer_t            w_sel;
    logic [SIZE_W-1:0] w_g0;
    logic [SIZE_W-1:0] w_g1;
    logic [SIZE_W-1:0] w_rem;
    queue_vec_t        w_grant;

    function automatic logic [SIZE_W-1:0] min3(input logic [SIZE_W-1:0] a,
                                               input logic [SIZE_W-1:0] b,
                                               input logic [SIZE_W-1:0] c);
        logic [SIZE_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    // latest offer from each uplink
    always_ff @(posedge i_clk) begin
        r_offer0 <= i_offer0;
        r_offer1 <= i_offer1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // grant rule
    ////////////////////////////////////////////////////////////////////////////

    assign w_sel = i_port ? r_offer1 : r_offer0;

    // ocs0 neighbour is served first, ocs1 gets what capacity is left
    assign w_g0  = min3(w_sel.sizes[i_next_hop.ocs0_tor], w_sel.capacity,
                        i_avail[i_next_hop.ocs0_tor]);
    assign w_rem = w_sel.capacity - w_g0;
    assign w_g1  = min3(w_sel.sizes[i_next_hop.ocs1_tor], w_rem,
                        i_avail[i_next_hop.ocs1_tor]);

    always_comb begin
        w_grant = '0;
        w_grant[i_next_hop.ocs0_tor] = w_g0;
        w_grant[i_next_hop.ocs1_tor] = w_g1;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_relay       <= '0;
            o_relay_valid <= 1'b0;
            o_relay_port  <= 1'b0;
        end else begin
            o_relay_valid <= i_compute;
            if (i_compute) begin
                o_relay      <= w_grant;
                o_relay_port <= i_port;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vlb_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_slot_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_slot_start,
    input  logic                       i_cur_slot_id,
    input  logic                       i_check_queue_resp_ready,
    input  logic [1:0]                 i_offer_valid,
    input  logic                       i_relay_valid,
    output logic                       o_check_queue_req_valid,
    output logic                       o_snapshot,
    output logic                       o_load,
    output logic [vlb_pkg::SLOT_W-1:0] o_slot_id,
    output logic                       o_compute,
    output logic                       o_port
);

    import vlb_pkg::*;

    logic                   r_slot_start;
    logic [SYNC_STAGES-1:0] r_resp_sync;
    logic                   r_ready;
    logic                   w_accept;

    ////////////////////////////////////////////////////////////////////////////
    // slot start and queue snapshot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_slot_start <= 1'b0;
            o_slot_id    <= '0;
        end else begin
            r_slot_start <= i_slot_start;
            if (i_slot_start) begin
                o_slot_id <= i_cur_slot_id;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_resp_sync <= '0;
        end else begin
            r_resp_sync <= {r_resp_sync[SYNC_STAGES-2:0], i_check_queue_resp_ready};
        end
    end

    // rising edge of the synchronised ready
    assign o_snapshot = r_resp_sync[SYNC_STAGES-2] & ~r_resp_sync[SYNC_STAGES-1];

    // drops on the edge where the last stage goes high
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (r_resp_sync[SYNC_STAGES-2]) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (r_slot_start) begin
            o_check_queue_req_valid <= 1'b1;
        end
    end

    // next hops and avail load one cycle after the snapshot
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_load <= 1'b0;
        end else begin
            o_load <= o_snapshot;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // offer arbitration
    ////////////////////////////////////////////////////////////////////////////

    // port 0 has priority, anything while busy is dropped
    assign w_accept = r_ready & (|i_offer_valid);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_ready <= 1'b1;
        end else if (i_relay_valid) begin
            r_ready <= 1'b1;
        end else if (w_accept) begin
            r_ready <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_compute <= 1'b0;
            o_port    <= 1'b0;
        end else begin
            o_compute <= w_accept;
            if (w_accept) begin
                o_port <= ~i_offer_valid[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_top (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_slot_start,
    input  logic                i_cur_slot_id,
    input  logic                i_check_queue_resp_ready,
    output logic                o_check_queue_req_valid,
    input  vlb_pkg::queue_vec_t i_local_queue_size,
    input  vlb_pkg::queue_vec_t i_unlocal_queue_size,
    input  vlb_pkg::offer_t     i_offer0,
    input  vlb_pkg::offer_t     i_offer1,
    input  logic                i_offer0_valid,
    input  logic                i_offer1_valid,
    output vlb_pkg::queue_vec_t o_relay,
    output logic                o_relay_valid,
    output logic                o_relay_port
);

    import vlb_pkg::*;

    logic              w_snapshot;
    logic              w_load;
    logic [SLOT_W-1:0] w_slot_id;
    logic              w_compute;
    logic              w_port;
    next_hop_t         w_next_hop;
    queue_vec_t        w_avail;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    vlb_slot_ctrl slot_ctrl_i (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_slot_start             (i_slot_start),
        .i_cur_slot_id            (i_cur_slot_id),
        .i_check_queue_resp_ready (i_check_queue_resp_ready),
        .i_offer_valid            ({i_offer1_valid, i_offer0_valid}),
        .i_relay_valid            (o_relay_valid),
        .o_check_queue_req_valid  (o_check_queue_req_valid),
        .o_snapshot               (w_snapshot),
        .o_load                   (w_load),
        .o_slot_id                (w_slot_id),
        .o_compute                (w_compute),
        .o_port                   (w_port)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    vlb_next_hop next_hop_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_load     (w_load),
        .i_slot_id  (w_slot_id),
        .o_next_hop (w_next_hop)
    );

    vlb_buffer_avail buffer_avail_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_snapshot     (w_snapshot),
        .i_local_size   (i_local_queue_size),
        .i_unlocal_size (i_unlocal_queue_size),
        .i_relay        (o_relay),
        .i_relay_valid  (o_relay_valid),
        .o_avail        (w_avail)
    );

    // grant feeds back into avail and the arbiter
    vlb_relay_calc relay_calc_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_compute     (w_compute),
        .i_port        (w_port),
        .i_offer0      (i_offer0),
        .i_offer1      (i_offer1),
        .i_next_hop    (w_next_hop),
        .i_avail       (w_avail),
        .o_relay       (o_relay),
        .o_relay_valid (o_relay_valid),
        .o_relay_port  (o_relay_port)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the relay core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module vlb_tb \
    -f vlb_relay.f -Mdir obj_dir -o vlb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/vlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "run passed"
    exit 0
fi
echo "run failed"
exit 1

// File: tb/vlb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_clk_gen (
    output logic o_clk
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// File: tb/vlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vlb_tb;

    import vlb_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int RAND_ITERS   = 40;
    localparam int RAND_OFFERS  = 4;
    // a slot with its snapshot takes about 16 cycles, an offer about 4
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 400
                                    + 2 * RAND_ITERS * (16 + 4 * RAND_OFFERS);

    logic       clk;
    logic       rst;
    logic       slot_start;
    logic       cur_slot_id;
    logic       resp_ready;
    logic       req_valid;
    queue_vec_t local_size;
    queue_vec_t unlocal_size;
    offer_t     offer0;
    offer_t     offer1;
    logic       offer0_valid;
    logic       offer1_valid;
    queue_vec_t relay;
    logic       relay_valid;
    logic       relay_port;

    // reference state
    queue_vec_t model_avail;
    logic       model_slot;

    integer     seed;
    int         cycles = 0;
    offer_t     stim;
    offer_t     other;
    queue_vec_t stim_local;
    queue_vec_t stim_unlocal;

    vlb_clk_gen clk_gen_i (.o_clk(clk));

    vlb_top dut_i (
        .i_clk                    (clk),
        .i_rst                    (rst),
        .i_slot_start             (slot_start),
        .i_cur_slot_id            (cur_slot_id),
        .i_check_queue_resp_ready (resp_ready),
        .o_check_queue_req_valid  (req_valid),
        .i_local_queue_size       (local_size),
        .i_unlocal_queue_size     (unlocal_size),
        .i_offer0                 (offer0),
        .i_offer1                 (offer1),
        .i_offer0_valid           (offer0_valid),
        .i_offer1_valid           (offer1_valid),
        .o_relay                  (relay),
        .o_relay_valid            (relay_valid),
        .o_relay_port             (relay_port)
    );

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        assert (expected === actual) else begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            fail_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // ocs0 neighbour first, ocs1 shares what capacity is left
    function automatic queue_vec_t expected_grant(input offer_t offer, input queue_vec_t avail,
                                                  input logic slot);
        int                next_slot;
        int                n0;
        int                n1;
        logic [SIZE_W-1:0] g0;
        logic [SIZE_W-1:0] g1;
        queue_vec_t        grant;
        next_slot = (int'(slot) + 1) % SLOT_NUM;
        n0 = (MY_TOR_ID + 1 + 2 * next_slot) % TOR_NUM;
        n1 = ((MY_TOR_ID - 1 - 2 * next_slot) % TOR_NUM + TOR_NUM) % TOR_NUM;
        g0 = offer.sizes[n0];
        g0 = (offer.capacity < g0) ? offer.capacity : g0;
        g0 = (avail[n0] < g0) ? avail[n0] : g0;
        g1 = offer.sizes[n1];
        g1 = ((offer.capacity - g0) < g1) ? (offer.capacity - g0) : g1;
        g1 = (avail[n1] < g1) ? avail[n1] : g1;
        grant = '0;
        grant[n0] = g0;
        grant[n1] = g1;
        return grant;
    endfunction

    function automatic offer_t flat_offer(input logic [SIZE_W-1:0] cap,
                                          input logic [SIZE_W-1:0] fill);
        offer_t o;
        o.capacity = cap;
        for (int q = 0; q < QUEUE_NUM; q++) begin
            o.sizes[q] = fill;
        end
        return o;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus sequences
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_slot(input logic id);
        int waited;
        cur_slot_id = id;
        slot_start = 1'b1;
        model_slot = id;
        @(negedge clk);
        slot_start = 1'b0;
        waited = 1;
        while (!req_valid && waited < 6) begin
            @(negedge clk);
            waited++;
        end
        check_value("slot_req_rise", 256'(2), 256'(waited));
    endtask

    task automatic take_snapshot(input queue_vec_t lq, input queue_vec_t uq);
        int waited;
        local_size = lq;
        unlocal_size = uq;
        resp_ready = 1'b1;
        waited = 0;
        while (req_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        check_value("snapshot_req_fall", 256'(3), 256'(waited));
        for (int q = 0; q < QUEUE_NUM; q++) begin
            model_avail[q] = SLOT_MAX_PKT - lq[q] - uq[q];
        end
        // synchroniser drains before the next slot start
        resp_ready = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("snapshot_req_low", 256'(0), 256'(req_valid));
        end
    endtask

    // poke1 strobes port 1 one cycle later, while the core is busy
    task automatic send_offer(input string name, input logic v0, input logic v1,
                              input offer_t o0, input offer_t o1, input logic poke1,
                              input int quiet);
        queue_vec_t exp_grant;
        logic       port;
        int         waited;
        port = ~v0;
        exp_grant = expected_grant(port ? o1 : o0, model_avail, model_slot);
        offer0 = o0;
        offer1 = o1;
        offer0_valid = v0;
        offer1_valid = v1;
        @(negedge clk);
        offer0_valid = 1'b0;
        offer1_valid = poke1;
        offer0 = '0;
        offer1 = poke1 ? o1 : '0;
        waited = 1;
        while (!relay_valid && waited < 6) begin
            @(negedge clk);
            offer1_valid = 1'b0;
            waited++;
        end
        check_value({name, "_latency"}, 256'(2), 256'(waited));
        check_value({name, "_port"}, 256'(port), 256'(relay_port));
        check_value({name, "_relay"}, exp_grant, relay);
        for (int q = 0; q < QUEUE_NUM; q++) begin
            model_avail[q] = model_avail[q] - exp_grant[q];
        end
        repeat (quiet) begin
            @(negedge clk);
            check_value({name, "_pulse"}, 256'(0), 256'(relay_valid));
        end
    endtask

    initial begin
        seed = 38;
        rst = 1'b1;
        slot_start = 1'b0;
        cur_slot_id = 1'b0;
        resp_ready = 1'b0;
        local_size = '0;
        unlocal_size = '0;
        offer0 = '0;
        offer1 = '0;
        offer0_valid = 1'b0;
        offer1_valid = 1'b0;
        model_avail = '0;
        model_slot = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("reset_req", 256'(0), 256'(req_valid));
            check_value("reset_relay", 256'(0), 256'(relay_valid));
        end

        // slot 0 goes to racks 3 and 5, slot 1 to racks 1 and 7
        start_slot(1'b0);
        take_snapshot('0, '0);
        stim = flat_offer(100, 500);
        stim.sizes[3] = 60;
        stim.sizes[5] = 70;
        send_offer("grant_slot0", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        check_value("grant_slot0_rack5", 256'(40), 256'(relay[5]));
        start_slot(1'b1);
        take_snapshot('0, '0);
        stim = flat_offer(150, 900);
        stim.sizes[1] = 30;
        stim.sizes[7] = 200;
        send_offer("grant_slot1", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        check_value("grant_slot1_rack7", 256'(120), 256'(relay[7]));

        // small avail on racks 3 and 5
        stim_local = '0;
        stim_unlocal = '0;
        stim_local[3] = 32'h0003_ff00;
        stim_unlocal[3] = 32'h0000_00c0;
        stim_local[5] = 32'h0003_ffe0;
        start_slot(1'b0);
        take_snapshot(stim_local, stim_unlocal);
        stim = flat_offer(1000, 0);
        stim.sizes[3] = 40;
        stim.sizes[5] = 20;
        send_offer("avail_first", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        send_offer("avail_second", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        check_value("avail_second_rack3", 256'(24), 256'(relay[3]));
        send_offer("avail_empty", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        start_slot(1'b0);
        take_snapshot(stim_local, stim_unlocal);
        send_offer("avail_restored", 1'b1, 1'b0, stim, '0, 1'b0, 1);
        check_value("avail_restored_rack3", 256'(40), 256'(relay[3]));

        // arbitration
        start_slot(1'b1);
        take_snapshot('0, '0);
        stim = flat_offer(50, 10);
        other = flat_offer(7, 3);
        send_offer("arb_both", 1'b1, 1'b1, stim, other, 1'b0, 5);
        send_offer("arb_busy", 1'b1, 1'b0, stim, other, 1'b1, 5);

        for (int it = 0; it < RAND_ITERS; it++) begin
            start_slot(1'($random(seed)));
            for (int q = 0; q < QUEUE_NUM; q++) begin
                stim_local[q] = $random(seed) & 32'h0001_ffff;
                stim_unlocal[q] = $random(seed) & 32'h0001_ffff;
            end
            take_snapshot(stim_local, stim_unlocal);
            for (int k = 0; k < RAND_OFFERS; k++) begin
                stim.capacity = $random(seed) & 32'h0003_ffff;
                for (int q = 0; q < QUEUE_NUM; q++) begin
                    stim.sizes[q] = $random(seed) & 32'h0001_ffff;
                end
                if ($random(seed) & 1) begin
                    send_offer("random_port1", 1'b0, 1'b1, '0, stim, 1'b0, 1);
                end else begin
                    send_offer("random_port0", 1'b1, 1'b0, stim, '0, 1'b0, 1);
                end
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlb_relay.f
hw/vlb_pkg.sv
hw/vlb_slot_ctrl.sv
hw/vlb_next_hop.sv
hw/vlb_buffer_avail.sv
hw/vlb_relay_calc.sv
hw/vlb_top.sv
tb/vlb_clk_gen.sv
tb/vlb_tb.sv
